//--- Bender.yml
package:
  name: ahb_subsystem

sources:
  - rtl/ahbPkg.sv
  - rtl/ahbLineMaster.sv
  - rtl/ahbArbiter.sv
  - rtl/ahbSramSlave.sv
  - rtl/ahbSubsystem.sv
  - target: test
    files:
      - testbench/tbAhbSubsystem.sv

//--- flist.f
rtl/ahbPkg.sv
rtl/ahbLineMaster.sv
rtl/ahbArbiter.sv
rtl/ahbSramSlave.sv
rtl/ahbSubsystem.sv
testbench/tbAhbSubsystem.sv

//--- rtl/ahbArbiter.sv
`timescale 1ns/1ns

module ahbArbiter (
	input  logic HCLK,
	input  logic HRESETn,
	input  logic HREADY,
	input  logic HBUSREQ0,
	input  logic HLOCK0,
	input  ahbPkg::transT HTRANS0,
	input  logic HWRITE0,
	input  ahbPkg::addrT HADDR0,
	input  ahbPkg::dataT HWDATA0,
	output logic HGRANT0,
	input  logic HBUSREQ1,
	input  logic HLOCK1,
	input  ahbPkg::transT HTRANS1,
	input  logic HWRITE1,
	input  ahbPkg::addrT HADDR1,
	input  ahbPkg::dataT HWDATA1,
	output logic HGRANT1,
	output ahbPkg::transT HTRANS,
	output logic HWRITE,
	output ahbPkg::addrT HADDR,
	output ahbPkg::dataT HWDATA
);

	logic grantValid;
	logic grantOwner;  // Also the round-robin pointer.
	logic nextValid;
	logic nextOwner;
	logic ownerHold;
	logic otherReq;
	logic addrValid;
	logic addrOwner;
	logic dataOwner;

	assign ownerHold = grantOwner ? (HBUSREQ1 || HLOCK1) : (HBUSREQ0 || HLOCK0);
	assign otherReq = grantOwner ? HBUSREQ0 : HBUSREQ1;

	always_comb begin
		nextValid = grantValid;
		nextOwner = grantOwner;
		if (!(grantValid && ownerHold)) begin
			if (otherReq) begin
				nextValid = 1'b1;
				nextOwner = !grantOwner;  // Move past the last owner.
			end else if (ownerHold) begin
				nextValid = 1'b1;
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			grantValid <= 1'b0;
			grantOwner <= 1'b1;  // Master 0 wins the first request.
			addrValid <= 1'b0;
			addrOwner <= 1'b0;
			dataOwner <= 1'b0;
		end else if (HREADY) begin
			grantValid <= nextValid;
			grantOwner <= nextOwner;
			addrValid <= grantValid;
			addrOwner <= grantOwner;
			dataOwner <= addrOwner;
		end
	end

	assign HGRANT0 = grantValid && !grantOwner;
	assign HGRANT1 = grantValid && grantOwner;

	assign HTRANS = !addrValid ? ahbPkg::TransIdle : (addrOwner ? HTRANS1 : HTRANS0);
	assign HWRITE = addrOwner ? HWRITE1 : HWRITE0;
	assign HADDR = addrOwner ? HADDR1 : HADDR0;
	assign HWDATA = dataOwner ? HWDATA1 : HWDATA0;  // Write data lags one phase.

endmodule

//--- rtl/ahbLineMaster.sv
`timescale 1ns/1ns

module ahbLineMaster (
	input  logic HCLK,
	input  logic HRESETn,
	input  logic MEnable,
	input  logic MRead,
	input  logic MWrite,
	input  ahbPkg::addrT MAddress,
	input  ahbPkg::dataT MWriteData,
	output ahbPkg::dataT MReadData,
	output logic MReady,
	output logic HBUSREQ,
	output logic HLOCK,
	input  logic HGRANT,
	output ahbPkg::transT HTRANS,
	output logic HWRITE,
	output ahbPkg::addrT HADDR,
	output ahbPkg::dataT HWDATA,
	input  logic HREADY,
	input  ahbPkg::dataT HRDATA
);

	localparam int BeatBits = $clog2(ahbPkg::LineBeats);
	localparam int OffsetBits = ahbPkg::LineOffsetBits;

	typedef enum logic [2:0] {
		Idle,
		Request,
		ReadFirst,
		ReadBurst,
		ReadLast,
		WriteAddr,
		WriteData
	} stateT;

	stateT state;
	stateT nextState;
	logic cmdRead;
	ahbPkg::addrT lineBase;
	ahbPkg::addrT beatAddr;
	logic [BeatBits-1:0] addrBeat;
	logic lastBeat;

	assign lastBeat = addrBeat == BeatBits'(ahbPkg::LineBeats - 1);
	assign beatAddr = lineBase + ahbPkg::addrT'({addrBeat, 2'b00});
	assign MReadData = HRDATA;  // Qualified by MReady.

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			cmdRead <= 1'b0;
			addrBeat <= '0;
		end else if (state == Idle) begin
			cmdRead <= MRead;
			addrBeat <= '0;
		end else if ((state == ReadFirst || state == ReadBurst) && HREADY) begin
			addrBeat <= addrBeat + 1'b1;  // Wraps after the last beat, unused then.
		end
	end

	always_ff @(posedge HCLK) begin
		if (state == Idle && MEnable && MRead) begin
			lineBase <= {MAddress[31:OffsetBits], {OffsetBits{1'b0}}};
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (MEnable && (MRead || MWrite)) begin
					nextState = Request;
				end
			end
			Request: begin
				if (HGRANT && HREADY) begin
					nextState = cmdRead ? ReadFirst : WriteAddr;
				end
			end
			ReadFirst: begin
				if (HREADY) begin
					nextState = ReadBurst;
				end
			end
			ReadBurst: begin
				if (HREADY && lastBeat) begin
					nextState = ReadLast;
				end
			end
			ReadLast: begin
				if (HREADY) begin
					nextState = Idle;
				end
			end
			WriteAddr: begin
				if (HREADY) begin
					nextState = WriteData;
				end
			end
			WriteData: begin
				if (HREADY) begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = Idle;
			end
		endcase
	end

	always_comb begin
		HTRANS = ahbPkg::TransIdle;
		HWRITE = 1'b0;
		HADDR = '0;
		HWDATA = '0;
		case (state)
			ReadFirst: begin
				HTRANS = ahbPkg::TransNonseq;
				HADDR = beatAddr;
			end
			ReadBurst: begin
				HTRANS = ahbPkg::TransSeq;  // Address beat n, data beat n-1.
				HADDR = beatAddr;
			end
			WriteAddr: begin
				HTRANS = ahbPkg::TransNonseq;
				HWRITE = 1'b1;
				HADDR = MAddress;
			end
			WriteData: begin
				HWDATA = MWriteData;
			end
			default: begin
				HTRANS = ahbPkg::TransIdle;
			end
		endcase
	end

	// Request is held through the last accepted address phase.
	assign HBUSREQ = state == Request || state == ReadFirst || state == ReadBurst ||
		state == WriteAddr;
	assign HLOCK = (state == Request && cmdRead) || state == ReadFirst ||
		state == ReadBurst;  // Keeps the burst whole.
	assign MReady = HREADY && (state == ReadBurst || state == ReadLast ||
		state == WriteData);

endmodule

//--- rtl/ahbPkg.sv
package ahbPkg;

	typedef logic [31:0] addrT;  // Byte address.
	typedef logic [31:0] dataT;  // One bus word.
	typedef logic [1:0] transT;

	localparam transT TransIdle = 2'd0;
	localparam transT TransNonseq = 2'd2;
	localparam transT TransSeq = 2'd3;  // BUSY is never issued.

	// A line refill is one incrementing burst of LineBeats words.
	localparam int LineBeats = 16;
	localparam int LineOffsetBits = 6;

endpackage

//--- rtl/ahbSramSlave.sv
`timescale 1ns/1ns

module ahbSramSlave #(
	parameter int MemWords = 1024,
	parameter int WaitStates = 0
) (
	input  logic HCLK,
	input  logic HRESETn,
	input  ahbPkg::transT HTRANS,
	input  logic HWRITE,
	input  ahbPkg::addrT HADDR,
	input  ahbPkg::dataT HWDATA,
	output logic HREADY,
	output ahbPkg::dataT HRDATA
);

	localparam int IndexBits = $clog2(MemWords);
	localparam int WaitBits = $clog2(WaitStates + 2);

	ahbPkg::dataT mem [MemWords];
	logic pending;
	logic pendWrite;
	logic [IndexBits-1:0] pendIndex;
	logic [WaitBits-1:0] waitCount;
	logic addrPhase;

	assign addrPhase = HTRANS == ahbPkg::TransNonseq || HTRANS == ahbPkg::TransSeq;

	// The data phase ends once all wait cycles have been spent.
	assign HREADY = !pending || waitCount == WaitBits'(WaitStates);
	assign HRDATA = (pending && !pendWrite) ? mem[pendIndex] : '0;

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			pending <= 1'b0;
			waitCount <= '0;
		end else if (HREADY) begin
			pending <= addrPhase;  // Next address phase taken as this one ends.
			waitCount <= '0;
		end else begin
			waitCount <= waitCount + 1'b1;
		end
	end

	always_ff @(posedge HCLK) begin
		if (HREADY && addrPhase) begin
			pendIndex <= HADDR[IndexBits+1:2];  // Word address wraps over the array.
			pendWrite <= HWRITE;
		end
	end

	always_ff @(posedge HCLK) begin
		if (HREADY && pending && pendWrite) begin
			mem[pendIndex] <= HWDATA;
		end
	end

endmodule

//--- rtl/ahbSubsystem.sv
`timescale 1ns/1ns

module ahbSubsystem #(
	parameter int MemWords = 1024,
	parameter int WaitStates = 0
) (
	input  logic HCLK,
	input  logic HRESETn,
	input  logic m0Enable,
	input  logic m0Read,
	input  logic m0Write,
	input  ahbPkg::addrT m0Address,
	input  ahbPkg::dataT m0WriteData,
	output ahbPkg::dataT m0ReadData,
	output logic m0Ready,
	input  logic m1Enable,
	input  logic m1Read,
	input  logic m1Write,
	input  ahbPkg::addrT m1Address,
	input  ahbPkg::dataT m1WriteData,
	output ahbPkg::dataT m1ReadData,
	output logic m1Ready
);

	logic busReq0, busReq1, lock0, lock1, grant0, grant1;
	logic write0, write1, hWrite, hReady;
	ahbPkg::transT trans0, trans1, hTrans;
	ahbPkg::addrT addr0, addr1, hAddr;
	ahbPkg::dataT wData0, wData1, hWData, hRData;

	ahbLineMaster master0 (
		.HCLK(HCLK), .HRESETn(HRESETn),
		.MEnable(m0Enable), .MRead(m0Read), .MWrite(m0Write),
		.MAddress(m0Address), .MWriteData(m0WriteData),
		.MReadData(m0ReadData), .MReady(m0Ready),
		.HBUSREQ(busReq0), .HLOCK(lock0), .HGRANT(grant0),
		.HTRANS(trans0), .HWRITE(write0), .HADDR(addr0), .HWDATA(wData0),
		.HREADY(hReady), .HRDATA(hRData)
	);

	ahbLineMaster master1 (
		.HCLK(HCLK), .HRESETn(HRESETn),
		.MEnable(m1Enable), .MRead(m1Read), .MWrite(m1Write),
		.MAddress(m1Address), .MWriteData(m1WriteData),
		.MReadData(m1ReadData), .MReady(m1Ready),
		.HBUSREQ(busReq1), .HLOCK(lock1), .HGRANT(grant1),
		.HTRANS(trans1), .HWRITE(write1), .HADDR(addr1), .HWDATA(wData1),
		.HREADY(hReady), .HRDATA(hRData)
	);

	ahbArbiter arbiter0 (
		.HCLK(HCLK), .HRESETn(HRESETn), .HREADY(hReady),
		.HBUSREQ0(busReq0), .HLOCK0(lock0), .HTRANS0(trans0), .HWRITE0(write0),
		.HADDR0(addr0), .HWDATA0(wData0), .HGRANT0(grant0),
		.HBUSREQ1(busReq1), .HLOCK1(lock1), .HTRANS1(trans1), .HWRITE1(write1),
		.HADDR1(addr1), .HWDATA1(wData1), .HGRANT1(grant1),
		.HTRANS(hTrans), .HWRITE(hWrite), .HADDR(hAddr), .HWDATA(hWData)
	);

	ahbSramSlave #(
		.MemWords(MemWords),
		.WaitStates(WaitStates)
	) sram0 (
		.HCLK(HCLK), .HRESETn(HRESETn),
		.HTRANS(hTrans), .HWRITE(hWrite), .HADDR(hAddr), .HWDATA(hWData),
		.HREADY(hReady), .HRDATA(hRData)
	);

endmodule

//--- testbench/tbAhbSubsystem.sv
`timescale 1ns/1ns

module tbAhbSubsystem;

	localparam int CmdTimeout = 400;  // Enough HCLK cycles to wait out a full burst by the other master.
	localparam logic [31:0] Seed = 32'hccfcb4d4;

	logic HCLK;
	logic HRESETn;
	logic m0Enable, m0Read, m0Write, m0Ready;
	logic m1Enable, m1Read, m1Write, m1Ready;
	ahbPkg::addrT m0Address, m1Address;
	ahbPkg::dataT m0WriteData, m1WriteData, m0ReadData, m1ReadData;

	logic exp0Read, exp1Read;
	ahbPkg::dataT exp0Data, exp1Data;
	ahbPkg::dataT refMem [int];  // Indexed by word address.
	logic [31:0] lcgState [2];
	time doneTime [2];

	ahbSubsystem #(
		.MemWords(1024),
		.WaitStates(1)
	) dut0 (
		.HCLK(HCLK), .HRESETn(HRESETn),
		.m0Enable(m0Enable), .m0Read(m0Read), .m0Write(m0Write),
		.m0Address(m0Address), .m0WriteData(m0WriteData),
		.m0ReadData(m0ReadData), .m0Ready(m0Ready),
		.m1Enable(m1Enable), .m1Read(m1Read), .m1Write(m1Write),
		.m1Address(m1Address), .m1WriteData(m1WriteData),
		.m1ReadData(m1ReadData), .m1Ready(m1Ready)
	);

	initial begin
		HCLK = 1'b0;
		forever #5 HCLK = ~HCLK;
	end

	task automatic failRun(input string line);
		$display("%s", line);
		$display("Regression failed");
		$fatal(1, "Stopping at the first error.");
	endtask

	function automatic logic [31:0] lcgNext(input int m);
		lcgState[m] = lcgState[m] * 32'd1664525 + 32'd1013904223;
		return lcgState[m];
	endfunction

	function automatic ahbPkg::dataT refWord(input ahbPkg::addrT addr);
		if (refMem.exists(int'(addr[31:2]))) begin
			return refMem[int'(addr[31:2])];
		end
		return 'x;  // Never written, so no read may expect it.
	endfunction

	function automatic logic readyOf(input int m);
		return m == 0 ? m0Ready : m1Ready;
	endfunction

	function automatic void setExpect(input int m, input logic isRead, input ahbPkg::dataT data);
		if (m == 0) begin
			exp0Read = isRead;
			exp0Data = data;
		end else begin
			exp1Read = isRead;
			exp1Data = data;
		end
	endfunction

	function automatic void driveClient(input int m, input logic en, input logic isRead,
		input ahbPkg::addrT addr, input ahbPkg::dataT data);
		if (m == 0) begin
			m0Enable = en;
			m0Read = en && isRead;
			m0Write = en && !isRead;
			m0Address = addr;
			m0WriteData = data;
		end else begin
			m1Enable = en;
			m1Read = en && isRead;
			m1Write = en && !isRead;
			m1Address = addr;
			m1WriteData = data;
		end
	endfunction

	// Runs one client command and counts its MReady pulses at mid-cycle.
	task automatic issueCommand(input int m, input logic isRead, input ahbPkg::addrT addr,
		input ahbPkg::dataT data);
		ahbPkg::addrT base;
		int need;
		int count;
		int cycles;
		logic sawReady;
		base = isRead ? (addr & ~32'h0000_003f) : addr;
		need = isRead ? ahbPkg::LineBeats : 1;
		count = 0;
		cycles = 0;
		@(posedge HCLK);
		#1;
		setExpect(m, isRead, refWord(base));
		driveClient(m, 1'b1, isRead, addr, data);
		while (count < need) begin
			if (cycles == CmdTimeout) begin
				failRun($sformatf("Timeout: master %0d %s at %h hung after %0d of %0d pulses",
					m, isRead ? "read" : "write", addr, count, need));
			end else begin
				@(negedge HCLK);
				sawReady = readyOf(m);
				@(posedge HCLK);
				if (sawReady) begin
					count++;
					if (!isRead) begin
						refMem[int'(addr[31:2])] = data;
					end else if (count < need) begin
						setExpect(m, 1'b1, refWord(base + ahbPkg::addrT'(4 * count)));
					end
				end
				cycles++;
			end
		end
		#1;
		driveClient(m, 1'b0, 1'b0, '0, '0);
		setExpect(m, 1'b0, '0);
		doneTime[m] = $time;
	endtask

	task automatic waitForReady(input int m);
		int cycles;
		cycles = 0;
		@(negedge HCLK);
		while (!readyOf(m)) begin
			cycles++;
			if (cycles > CmdTimeout) begin
				failRun($sformatf("Timeout: master %0d never raised MReady", m));
			end else begin
				@(negedge HCLK);
			end
		end
	endtask

	task automatic writeLine(input int m, input int line);
		for (int i = 0; i < ahbPkg::LineBeats; i++) begin
			issueCommand(m, 1'b0, ahbPkg::addrT'(line * 64 + i * 4), lcgNext(m));
		end
	endtask

	// Writes stay in the master's own lines 0-3 or 4-7, reads also reach shared lines 8-11.
	task automatic randomCommand(input int m);
		logic [31:0] r;
		int line;
		r = lcgNext(m);
		if (r[31]) begin
			line = (m == 0 ? 0 : 4) + int'(r[29:28]);
			issueCommand(m, 1'b0, ahbPkg::addrT'(line * 64 + int'(r[27:24]) * 4), lcgNext(m));
		end else begin
			line = (r[30] ? 8 : (m == 0 ? 0 : 4)) + int'(r[29:28]);
			issueCommand(m, 1'b1, ahbPkg::addrT'(line * 64 + int'(r[23:18])), '0);
		end
	endtask

	resetQuiet: assert property (@(posedge HCLK) !HRESETn |=> (!m0Ready && !m1Ready))
		else failRun($sformatf("FAIL %0t: MReady high during or right after reset", $time));

	idleQuiet0: assert property (@(posedge HCLK) disable iff (!HRESETn) !m0Enable |-> !m0Ready)
		else failRun($sformatf("FAIL %0t: m0Ready while m0Enable is low", $time));

	idleQuiet1: assert property (@(posedge HCLK) disable iff (!HRESETn) !m1Enable |-> !m1Ready)
		else failRun($sformatf("FAIL %0t: m1Ready while m1Enable is low", $time));

	readData0: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(m0Ready && exp0Read) |-> m0ReadData == exp0Data)
		else failRun($sformatf("FAIL %0t: m0 read data %h, expected %h", $time,
			$sampled(m0ReadData), $sampled(exp0Data)));

	readData1: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(m1Ready && exp1Read) |-> m1ReadData == exp1Data)
		else failRun($sformatf("FAIL %0t: m1 read data %h, expected %h", $time,
			$sampled(m1ReadData), $sampled(exp1Data)));

	initial begin
		HRESETn = 1'b0;
		driveClient(0, 1'b0, 1'b0, '0, '0);
		driveClient(1, 1'b0, 1'b0, '0, '0);
		setExpect(0, 1'b0, '0);
		setExpect(1, 1'b0, '0);
		lcgState[0] = Seed;
		lcgState[1] = ~Seed;
		doneTime[0] = 0;
		doneTime[1] = 0;
		repeat (2) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		fork
			for (int l = 0; l < 4; l++) writeLine(0, l);
			for (int l = 4; l < 8; l++) writeLine(1, l);
		join

		// Lines written by m1 are read back through m0.
		for (int l = 8; l < 12; l++) begin
			writeLine(1, l);
			issueCommand(0, 1'b1, ahbPkg::addrT'(l * 64), '0);
		end

		issueCommand(0, 1'b0, 32'h0000_0014, lcgNext(0));
		issueCommand(0, 1'b1, 32'h0000_0027, '0);  // Unaligned address inside the line at 0x00.
		issueCommand(1, 1'b0, 32'h0000_0130, lcgNext(1));
		issueCommand(1, 1'b1, 32'h0000_013d, '0);

		fork
			issueCommand(0, 1'b1, 32'h0000_0208, '0);
			begin
				waitForReady(0);
				issueCommand(1, 1'b1, 32'h0000_0244, '0);
			end
		join
		burstOrder: assert (doneTime[1] > doneTime[0])
			else failRun($sformatf("FAIL %0t: m1 read finished before the m0 burst", $time));

		fork
			for (int i = 0; i < 200; i++) randomCommand(0);
			for (int i = 0; i < 200; i++) randomCommand(1);
		join

		$display("Regression passed");
		$finish;
	end

endmodule
